// ==== hdl/cryo_pkg.sv ====
package cryo_pkg;

	// Local bus
	localparam int LB_AW = 17;
	localparam int LB_DW = 32;
	// Offset within one half of the address space
	localparam int LB_OFS_W = LB_AW - 1;

	// Field and drive datapath
	localparam int FIELD_W = 18;
	localparam int FIELD_MAX = 2**(FIELD_W-1) - 1;
	localparam int KP_W = 12;
	localparam int KP_SHIFT = 8;
	// Error is one bit wider than a field, gain gets a sign bit
	localparam int PROD_W = (FIELD_W + 1) + (KP_W + 1);

	typedef logic signed [FIELD_W-1:0] field_t;

	// Cavity model
	localparam int SHIFT_W = 4;
	localparam int DECAY_SHIFT_RST = 3;
	localparam int SAMPLE_DIV = 4;
	localparam int DIV_W = $clog2(SAMPLE_DIV);

	// Sample FIFO
	localparam int FIFO_AW = 4;
	localparam int FIFO_DEPTH = 2**FIFO_AW;

	// Controller half, lb_addr[16] clear
	localparam logic [LB_OFS_W-1:0] REG_SETPOINT = 'd0;
	localparam logic [LB_OFS_W-1:0] REG_KP = 'd1;
	localparam logic [LB_OFS_W-1:0] REG_FF = 'd2;
	localparam logic [LB_OFS_W-1:0] REG_CTRL = 'd3;
	localparam logic [LB_OFS_W-1:0] REG_LAST_FIELD = 'd4;
	localparam logic [LB_OFS_W-1:0] REG_DRIVE = 'd5;
	localparam logic [LB_OFS_W-1:0] REG_STATUS = 'd6;
	localparam logic [LB_OFS_W-1:0] REG_LEVEL = 'd7;

	// Simulator half, lb_addr[16] set
	localparam logic [LB_OFS_W-1:0] REG_SHIFT = 'd0;
	localparam logic [LB_OFS_W-1:0] REG_SIM_EN = 'd1;
	localparam logic [LB_OFS_W-1:0] REG_FIELD = 'd2;
	localparam logic [LB_OFS_W-1:0] REG_COUNT = 'd3;

endpackage

// ==== hdl/lb_decode.sv ====
`timescale 1ns/1ps

module lb_decode import cryo_pkg::*; (
	input  logic                 clk1x,
	input  logic                 rst_n,

	// Local bus
	input  logic [LB_AW-1:0]     lb_addr,
	input  logic [LB_DW-1:0]     lb_data,
	input  logic                 lb_write,
	input  logic                 lb_read,
	output logic [LB_DW-1:0]     lb_out,

	// Status gathered from the loop
	input  field_t               last_field,
	input  field_t               drive,
	input  field_t               field,
	input  logic [31:0]          sample_count,
	input  logic [FIFO_AW:0]     level,
	input  logic                 overflow,

	// Controller settings
	output field_t               setpoint,
	output field_t               ff_drive,
	output logic [KP_W-1:0]      kp,
	output logic                 hold,

	// Simulator settings
	output logic [SHIFT_W-1:0]   decay_shift,
	output logic                 sim_en,

	output logic                 ovf_clear
);

	logic                sim_sel;
	logic [LB_OFS_W-1:0] ofs;
	logic [LB_DW-1:0]    rd_word;

	// Upper half belongs to the simulator
	assign sim_sel = lb_addr[LB_AW-1];
	assign ofs = lb_addr[LB_OFS_W-1:0];

	// Write-one-to-clear on the status register
	assign ovf_clear = lb_write && !sim_sel && (ofs == REG_STATUS) && lb_data[0];

	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			setpoint <= '0;
			ff_drive <= '0;
			kp <= '0;
			hold <= 1'b0;
			decay_shift <= SHIFT_W'(DECAY_SHIFT_RST);
			sim_en <= 1'b0;
		end else if (lb_write) begin
			if (sim_sel) begin
				case (ofs)
					REG_SHIFT:  decay_shift <= lb_data[SHIFT_W-1:0];
					REG_SIM_EN: sim_en <= lb_data[0];
					default: ;
				endcase
			end else begin
				case (ofs)
					REG_SETPOINT: setpoint <= field_t'(lb_data[FIELD_W-1:0]);
					REG_KP:       kp <= lb_data[KP_W-1:0];
					REG_FF:       ff_drive <= field_t'(lb_data[FIELD_W-1:0]);
					REG_CTRL:     hold <= lb_data[0];
					default: ;
				endcase
			end
		end
	end

	// Read mux, field values sign-extended, the rest zero-extended
	always_comb begin
		rd_word = '0;
		if (sim_sel) begin
			case (ofs)
				REG_SHIFT:  rd_word = LB_DW'(decay_shift);
				REG_SIM_EN: rd_word = LB_DW'(sim_en);
				REG_FIELD:  rd_word = LB_DW'(field);
				REG_COUNT:  rd_word = LB_DW'(sample_count);
				default:    rd_word = '0;
			endcase
		end else begin
			case (ofs)
				REG_SETPOINT:   rd_word = LB_DW'(setpoint);
				REG_KP:         rd_word = LB_DW'(kp);
				REG_FF:         rd_word = LB_DW'(ff_drive);
				REG_CTRL:       rd_word = LB_DW'(hold);
				REG_LAST_FIELD: rd_word = LB_DW'(last_field);
				REG_DRIVE:      rd_word = LB_DW'(drive);
				REG_STATUS:     rd_word = LB_DW'(overflow);
				REG_LEVEL:      rd_word = LB_DW'(level);
				default:        rd_word = '0;
			endcase
		end
	end

	// Read data holds until the next read strobe
	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			lb_out <= '0;
		end else if (lb_read) begin
			lb_out <= rd_word;
		end
	end

endmodule

// ==== hdl/cavity_model.sv ====
`timescale 1ns/1ps

module cavity_model import cryo_pkg::*; (
	input  logic                clk1x,
	input  logic                rst_n,

	input  logic                sim_en,
	input  logic [SHIFT_W-1:0]  decay_shift,
	input  field_t              drive,

	// Sample stream to the FIFO
	output logic                samp_valid,
	output field_t              samp_field,

	// Status
	output field_t              field,
	output logic [31:0]         sample_count
);

	logic [DIV_W-1:0]       div;
	logic                   tick;
	logic signed [FIELD_W:0] diff;
	logic signed [FIELD_W:0] step;
	logic signed [FIELD_W:0] next_ext;
	field_t                 field_next;

	// Update slot at the end of each divider period
	assign tick = sim_en && (div == DIV_W'(SAMPLE_DIV - 1));

	// First-order response, one extra bit keeps the difference exact
	always_comb begin
		diff = (FIELD_W+1)'(drive) - (FIELD_W+1)'(field);
		// Arithmetic shift rounds toward minus infinity
		step = diff >>> decay_shift;
		next_ext = (FIELD_W+1)'(field) + step;
		// Result lies between field and drive so it always fits
		field_next = field_t'(next_ext[FIELD_W-1:0]);
	end

	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			div <= '0;
		end else if (sim_en) begin
			if (tick) begin
				div <= '0;
			end else begin
				div <= div + 1'b1;
			end
		end
	end

	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			field <= '0;
			sample_count <= '0;
			samp_valid <= 1'b0;
		end else begin
			samp_valid <= tick;
			if (tick) begin
				field <= field_next;
				sample_count <= sample_count + 32'd1;
			end
		end
	end

	// New field and its valid pulse leave on the same edge
	assign samp_field = field;

	// A frozen model emits nothing on the following cycle
	a_no_sample_when_frozen: assert property (
		@(posedge clk1x) disable iff (!rst_n)
		!sim_en |=> !samp_valid
	);

endmodule

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo import cryo_pkg::*; (
	input  logic              clk1x,
	input  logic              rst_n,

	// Write side from the cavity model
	input  logic              wr_en,
	input  field_t            wr_data,

	// Read side to the controller
	input  logic              rd_en,
	output field_t            rd_data,
	output logic              empty,

	input  logic              ovf_clear,
	output logic [FIFO_AW:0]  level,
	output logic              overflow
);

	field_t             mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               wr_ok;
	logic               rd_ok;

	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign level = count;

	// Writes into a full buffer are lost
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	always_ff @(posedge clk1x) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
		if (rd_ok) begin
			rd_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (FIFO_AW+1)'(wr_ok) - (FIFO_AW+1)'(rd_ok);
			if (ovf_clear) begin
				overflow <= 1'b0;
			end
			// A new drop wins over a clear in the same cycle
			if (wr_en && full) begin
				overflow <= 1'b1;
			end
		end
	end

	a_no_read_when_empty: assert property (
		@(posedge clk1x) disable iff (!rst_n)
		rd_en |-> !empty
	);

	a_level_in_range: assert property (
		@(posedge clk1x) disable iff (!rst_n)
		count <= (FIFO_AW+1)'(FIFO_DEPTH)
	);

endmodule

// ==== hdl/fdbk_core.sv ====
`timescale 1ns/1ps

module fdbk_core import cryo_pkg::*; (
	input  logic              clk1x,
	input  logic              rst_n,

	// FIFO read side
	input  logic              empty,
	input  field_t            rd_data,
	output logic              rd_en,

	// Settings
	input  logic              hold,
	input  field_t            setpoint,
	input  logic [KP_W-1:0]   kp,
	input  field_t            ff_drive,

	output field_t            last_field,
	output field_t            drive
);

	logic                     data_vld;
	logic                     prod_vld;
	logic signed [FIELD_W:0]  err;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] prod_q;
	field_t                   field_q;
	logic signed [PROD_W-1:0] sum;
	field_t                   drive_sat;

	// Drain the FIFO whenever allowed, one sample per cycle
	assign rd_en = !empty && !hold;

	// Stage 1, error and gain product
	always_comb begin
		err = (FIELD_W+1)'(setpoint) - (FIELD_W+1)'(rd_data);
		prod = err * $signed({1'b0, kp});
	end

	// Stage 2, feedforward plus scaled product, then clip
	always_comb begin
		sum = PROD_W'(ff_drive) + (prod_q >>> KP_SHIFT);
		if (sum > FIELD_MAX) begin
			drive_sat = field_t'(FIELD_MAX);
		end else if (sum < -FIELD_MAX) begin
			drive_sat = field_t'(-FIELD_MAX);
		end else begin
			drive_sat = field_t'(sum[FIELD_W-1:0]);
		end
	end

	// Valid flags follow each sample down the pipe
	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			data_vld <= 1'b0;
			prod_vld <= 1'b0;
		end else begin
			data_vld <= rd_en;
			prod_vld <= data_vld;
		end
	end

	always_ff @(posedge clk1x) begin
		if (data_vld) begin
			prod_q <= prod;
			field_q <= rd_data;
		end
	end

	// Field and the drive computed from it change together
	always_ff @(posedge clk1x) begin
		if (!rst_n) begin
			last_field <= '0;
			drive <= '0;
		end else if (prod_vld) begin
			last_field <= field_q;
			drive <= drive_sat;
		end
	end

	a_drive_in_bounds: assert property (
		@(posedge clk1x) disable iff (!rst_n)
		(drive <= FIELD_MAX) && (drive >= -FIELD_MAX)
	);

endmodule

// ==== hdl/cryomodule.sv ====
`timescale 1ns/1ps

module cryomodule import cryo_pkg::*; (
	input  logic              clk1x,
	input  logic              rst_n,

	// Simulator in the upper half, controller in the lower half
	input  logic [LB_AW-1:0]  lb_addr,
	input  logic [LB_DW-1:0]  lb_data,
	input  logic              lb_write,
	input  logic              lb_read,
	output logic [LB_DW-1:0]  lb_out
);

	// Controller settings
	field_t               setpoint;
	field_t               ff_drive;
	logic [KP_W-1:0]      kp;
	logic                 hold;

	// Simulator settings
	logic [SHIFT_W-1:0]   decay_shift;
	logic                 sim_en;

	// Sample path through the FIFO
	logic                 samp_valid;
	field_t               samp_field;
	logic                 rd_en;
	field_t               rd_data;
	logic                 empty;
	logic [FIFO_AW:0]     level;
	logic                 overflow;
	logic                 ovf_clear;

	// Loop state
	field_t               field;
	field_t               last_field;
	field_t               drive;
	logic [31:0]          sample_count;

	lb_decode lb_decode0 (
		.clk1x(clk1x), .rst_n(rst_n),
		.lb_addr(lb_addr), .lb_data(lb_data),
		.lb_write(lb_write), .lb_read(lb_read), .lb_out(lb_out),
		.last_field(last_field), .drive(drive), .field(field),
		.sample_count(sample_count), .level(level), .overflow(overflow),
		.setpoint(setpoint), .ff_drive(ff_drive), .kp(kp), .hold(hold),
		.decay_shift(decay_shift), .sim_en(sim_en),
		.ovf_clear(ovf_clear)
	);

	cavity_model cavity0 (
		.clk1x(clk1x), .rst_n(rst_n),
		.sim_en(sim_en), .decay_shift(decay_shift), .drive(drive),
		.samp_valid(samp_valid), .samp_field(samp_field),
		.field(field), .sample_count(sample_count)
	);

	sample_fifo fifo0 (
		.clk1x(clk1x), .rst_n(rst_n),
		.wr_en(samp_valid), .wr_data(samp_field),
		.rd_en(rd_en), .rd_data(rd_data), .empty(empty),
		.ovf_clear(ovf_clear), .level(level), .overflow(overflow)
	);

	// Drive closes the loop back into the cavity model
	fdbk_core fdbk0 (
		.clk1x(clk1x), .rst_n(rst_n),
		.empty(empty), .rd_data(rd_data), .rd_en(rd_en),
		.hold(hold), .setpoint(setpoint), .kp(kp), .ff_drive(ff_drive),
		.last_field(last_field), .drive(drive)
	);

endmodule

// ==== sim/cryomodule_tb.sv ====
`timescale 1ns/1ps

module cryomodule_tb import cryo_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int SHIFT_RESET = 3;
	localparam int DRIVE_MAX = 2**(FIELD_W-1) - 1;
	// Loop settles within this many cycles after a freeze
	localparam int QUIET_CYC = 8 + 16*3;
	// Updates after reset that still see the reset drive of 0
	localparam int LOOP_LAG = 2;
	localparam int N_REG_ROUNDS = 48;
	localparam int N_LOOP_ROUNDS = 8;
	localparam int MIN_RUN = 40;
	localparam int RUN_MAX = 300;
	localparam int HOLD_SAMPLES = 20;
	// Rough cost of one bus write plus one bus read
	localparam int BUS_CYC = 5;
	localparam int TOTAL_CYCLES = 100 + 3 * 2 * RESET_CYCLES
		+ (12 + 16 + N_REG_ROUNDS) * BUS_CYC
		+ (2 + N_LOOP_ROUNDS) * (RUN_MAX + QUIET_CYC + 8 * BUS_CYC)
		+ HOLD_SAMPLES * SAMPLE_DIV + 2 * QUIET_CYC + 10 * BUS_CYC;

	logic             clk1x;
	logic             rst_n;
	logic [LB_AW-1:0] lb_addr;
	logic [LB_DW-1:0] lb_data;
	logic             lb_write;
	logic             lb_read;
	logic [LB_DW-1:0] lb_out;

	cryomodule dut0 (
		.clk1x(clk1x), .rst_n(rst_n),
		.lb_addr(lb_addr), .lb_data(lb_data),
		.lb_write(lb_write), .lb_read(lb_read), .lb_out(lb_out)
	);

	always #(CLK_PERIOD/2) clk1x = ~clk1x;

	task automatic apply_reset();
		@(posedge clk1x);
		rst_n <= 1'b0;
		lb_write <= 1'b0;
		lb_read <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk1x);
		rst_n <= 1'b1;
	endtask

	task automatic bus_write(input logic sim, input logic [LB_OFS_W-1:0] ofs,
			input logic [LB_DW-1:0] data);
		@(posedge clk1x);
		lb_addr <= {sim, ofs};
		lb_data <= data;
		lb_write <= 1'b1;
		@(posedge clk1x);
		lb_write <= 1'b0;
	endtask

	// Read data is taken one cycle after the strobe
	task automatic bus_read(input logic sim, input logic [LB_OFS_W-1:0] ofs,
			output logic [LB_DW-1:0] data);
		@(posedge clk1x);
		lb_addr <= {sim, ofs};
		lb_read <= 1'b1;
		@(posedge clk1x);
		lb_read <= 1'b0;
		@(negedge clk1x);
		data = lb_out;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Run the cavity for a while, then freeze it and let the loop drain
	task automatic run_loop(input int cycles);
		bus_write(1'b1, REG_SIM_EN, 32'd1);
		repeat (cycles) @(posedge clk1x);
		bus_write(1'b1, REG_SIM_EN, 32'd0);
		repeat (QUIET_CYC) @(posedge clk1x);
	endtask

	function automatic int random_run();
		return MIN_RUN + int'($urandom % (RUN_MAX - MIN_RUN));
	endfunction

	function automatic int rand_field();
		field_t r;
		r = field_t'($urandom);
		return int'(r);
	endfunction

	function automatic logic [31:0] sext_field(input logic [31:0] d);
		return {{(LB_DW-FIELD_W){d[FIELD_W-1]}}, d[FIELD_W-1:0]};
	endfunction

	function automatic logic [31:0] low_bits(input logic [31:0] d, input int w);
		return d & ((32'd1 << w) - 32'd1);
	endfunction

	function automatic int sat_drive(input longint v);
		if (v > DRIVE_MAX) begin
			return DRIVE_MAX;
		end else if (v < -DRIVE_MAX) begin
			return -DRIVE_MAX;
		end else begin
			return int'(v);
		end
	endfunction

	// One first-order step, arithmetic shift gives floor for negatives
	function automatic int decay_step(input int f, input int d, input int s);
		return f + ((d - f) >>> s);
	endfunction

	initial begin
		#(2 * TOTAL_CYCLES * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		int ff;
		int sp;
		int kp_val;
		int shift;
		int drv;
		int lf;
		int sel;
		int exp_field;
		longint prod;
		logic sim;
		logic [LB_OFS_W-1:0] ofs;
		logic [31:0] data;
		logic [31:0] rd;
		logic [31:0] cnt;
		logic [31:0] cnt0;
		logic [31:0] want;

		clk1x = 1'b0;
		rst_n = 1'b0;
		lb_addr = '0;
		lb_data = '0;
		lb_write = 1'b0;
		lb_read = 1'b0;
		void'($urandom(32'hb12e));
		apply_reset();

		// Reset values of both halves
		for (int i = 0; i < 8; i++) begin
			bus_read(1'b0, LB_OFS_W'(i), rd);
			check_value(rd, 32'd0, "controller register after reset");
		end
		for (int i = 0; i < 4; i++) begin
			bus_read(1'b1, LB_OFS_W'(i), rd);
			want = (LB_OFS_W'(i) == REG_SHIFT) ? 32'(SHIFT_RESET) : 32'd0;
			check_value(rd, want, "simulator register after reset");
		end

		// Read-only and unmapped offsets ignore writes while the loop is idle
		bus_write(1'b0, REG_LAST_FIELD, $urandom);
		bus_write(1'b0, REG_DRIVE, $urandom);
		bus_write(1'b0, REG_STATUS, $urandom);
		bus_write(1'b0, REG_LEVEL, $urandom);
		bus_write(1'b1, REG_FIELD, $urandom);
		bus_write(1'b1, REG_COUNT, $urandom);
		bus_read(1'b0, REG_LAST_FIELD, rd);
		check_value(rd, 32'd0, "last field after write");
		bus_read(1'b0, REG_DRIVE, rd);
		check_value(rd, 32'd0, "drive after write");
		bus_read(1'b0, REG_STATUS, rd);
		check_value(rd, 32'd0, "status after write");
		bus_read(1'b0, REG_LEVEL, rd);
		check_value(rd, 32'd0, "level after write");
		bus_read(1'b1, REG_FIELD, rd);
		check_value(rd, 32'd0, "field after write");
		bus_read(1'b1, REG_COUNT, rd);
		check_value(rd, 32'd0, "count after write");
		for (int i = 0; i < 8; i++) begin
			sim = i[0];
			ofs = LB_OFS_W'((sim ? 4 : 8) + $urandom % ((2**LB_OFS_W) - 8));
			bus_write(sim, ofs, $urandom);
			bus_read(sim, ofs, rd);
			check_value(rd, 32'd0, "unmapped offset");
		end

		// Writable registers, masked or sign-extended on readback
		for (int i = 0; i < N_REG_ROUNDS; i++) begin
			sel = $urandom % 6;
			data = $urandom;
			sim = (sel >= 4);
			case (sel)
				0: ofs = REG_SETPOINT;
				1: ofs = REG_KP;
				2: ofs = REG_FF;
				3: ofs = REG_CTRL;
				4: ofs = REG_SHIFT;
				default: ofs = REG_SIM_EN;
			endcase
			case (sel)
				0, 2: want = sext_field(data);
				1: want = low_bits(data, KP_W);
				4: want = low_bits(data, SHIFT_W);
				default: want = low_bits(data, 1);
			endcase
			bus_write(sim, ofs, data);
			bus_read(sim, ofs, rd);
			check_value(rd, want, "writable register readback");
		end

		// Open loop with kp at 0, so drive settles at the clipped feedforward
		apply_reset();
		ff = rand_field();
		shift = $urandom % 16;
		drv = sat_drive(ff);
		bus_write(1'b0, REG_FF, 32'(ff));
		bus_write(1'b1, REG_SHIFT, 32'(shift));
		run_loop(random_run());
		bus_read(1'b1, REG_COUNT, cnt0);
		bus_read(1'b1, REG_FIELD, rd);
		exp_field = 0;
		for (int i = 0; i < int'(cnt0); i++) begin
			exp_field = decay_step(exp_field, (i < LOOP_LAG) ? 0 : drv, shift);
		end
		check_value(rd, 32'(exp_field), "open-loop field from reset");
		run_loop(random_run());
		bus_read(1'b1, REG_COUNT, cnt);
		bus_read(1'b1, REG_FIELD, rd);
		for (int i = 0; i < int'(cnt - cnt0); i++) begin
			exp_field = decay_step(exp_field, drv, shift);
		end
		check_value(rd, 32'(exp_field), "open-loop field continued");

		// Closed loop, drive rule applied to the last field
		for (int r = 0; r < N_LOOP_ROUNDS; r++) begin
			sp = rand_field();
			kp_val = $urandom % (2**KP_W);
			ff = rand_field();
			case (r % 3)
				1: begin
					kp_val = $urandom % 64;
					ff = int'($urandom % 4096) - 2048;
				end
				2: ff = (r % 2) ? DRIVE_MAX : -DRIVE_MAX - 1;
				default: ;
			endcase
			bus_write(1'b0, REG_SETPOINT, 32'(sp));
			bus_write(1'b0, REG_KP, 32'(kp_val));
			bus_write(1'b0, REG_FF, 32'(ff));
			bus_write(1'b1, REG_SHIFT, $urandom % 16);
			run_loop(random_run());
			bus_read(1'b0, REG_LAST_FIELD, rd);
			lf = int'($signed(rd));
			bus_read(1'b0, REG_DRIVE, rd);
			prod = (longint'(kp_val) * longint'(sp - lf)) >>> KP_SHIFT;
			check_value(rd, 32'(sat_drive(longint'(ff) + prod)), "drive from last field");
		end

		// Hold blocks reads, the FIFO fills and drops samples
		bus_write(1'b0, REG_CTRL, 32'd1);
		run_loop(HOLD_SAMPLES * SAMPLE_DIV + SAMPLE_DIV);
		bus_read(1'b0, REG_LEVEL, rd);
		check_value(rd, 32'(FIFO_DEPTH), "level while held");
		bus_read(1'b0, REG_STATUS, rd);
		check_value(rd, 32'd1, "overflow while held");
		bus_write(1'b0, REG_CTRL, 32'd0);
		repeat (QUIET_CYC) @(posedge clk1x);
		bus_read(1'b0, REG_LEVEL, rd);
		check_value(rd, 32'd0, "level after drain");
		bus_read(1'b0, REG_STATUS, rd);
		check_value(rd, 32'd1, "overflow is sticky");
		bus_write(1'b0, REG_STATUS, 32'd1);
		bus_read(1'b0, REG_STATUS, rd);
		check_value(rd, 32'd0, "overflow after clear");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/cryo_pkg.sv
hdl/lb_decode.sv
hdl/cavity_model.sv
hdl/sample_fifo.sv
hdl/fdbk_core.sv
hdl/cryomodule.sv
sim/cryomodule_tb.sv
